//--- Bender.yml
package:
  name: vldu

sources:
  - verilog/vldu_pkg.sv
  - verilog/vldu_insn_queue.sv
  - verilog/vldu_beat_packer.sv
  - verilog/vldu_result_queue.sv
  - verilog/vldu_top.sv
  - target: test
    files:
      - tb/tb_vldu.sv

//--- src.f
verilog/vldu_pkg.sv
verilog/vldu_insn_queue.sv
verilog/vldu_beat_packer.sv
verilog/vldu_result_queue.sv
verilog/vldu_top.sv
tb/tb_vldu.sv

//--- tb/tb_vldu.sv
// Directed testbench for the vector load unit with memory model, lane grant model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_vldu;

  import vldu_pkg::*;

  // Five short tests, none longer than a few hundred cycles
  localparam int unsigned MaxCycles = 3000;

  logic     clk;
  logic     rst_n;
  pe_req_t  pe_req;
  logic     pe_req_valid;
  logic     pe_req_ready;
  pe_resp_t pe_resp;
  // Driven by the memory and lane models below
  r_beat_t  r_beat = '0;
  logic     r_valid = 1'b0;
  logic     r_ready;
  lane_result_t [NrLanes-1:0] ldu_result;
  logic [NrLanes-1:0] ldu_result_req;
  logic [NrLanes-1:0] ldu_result_gnt = '0;

  // Scoreboard
  lane_result_t exp_q [NrLanes][$];
  lane_result_t got_q [NrLanes][$];
  pe_resp_t     resp_exp_q[$];
  pe_resp_t     resp_got_q[$];
  r_beat_t      beat_q[$];

  // Model state
  logic [NrLanes-1:0] granted = '0;
  int unsigned wait_cnt [NrLanes];
  int unsigned max_delay;
  logic        grants_held;
  logic        mem_fire = 1'b0;
  logic        stall_seen;

  int unsigned cycles;
  int unsigned checks;
  int unsigned errors;
  int unsigned tests;
  int unsigned test_start_errors;

  vldu_top u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .pe_req_i         (pe_req),
    .pe_req_valid_i   (pe_req_valid),
    .pe_req_ready_o   (pe_req_ready),
    .pe_resp_o        (pe_resp),
    .r_beat_i         (r_beat),
    .r_valid_i        (r_valid),
    .r_ready_o        (r_ready),
    .ldu_result_o     (ldu_result),
    .ldu_result_req_o (ldu_result_req),
    .ldu_result_gnt_i (ldu_result_gnt)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Models and monitors
  //////////////////////////////////////////////////////////////////////

  // Everything is stable at the falling edge
  always @(negedge clk) begin : monitor
    for (int l = 0; l < NrLanes; l++) begin
      granted[l] = rst_n && ldu_result_req[l] && ldu_result_gnt[l];
      if (granted[l]) begin
        got_q[l].push_back(ldu_result[l]);
      end
    end
    if (rst_n && (pe_resp != '0)) begin
      resp_got_q.push_back(pe_resp);
    end
    if (r_valid && !r_ready) begin
      stall_seen = 1'b1;
    end
    mem_fire = r_valid && r_ready;
  end

  // Beats go out in order, one per handshake
  always @(posedge clk) begin : memory_model
    #2;
    if (mem_fire) begin
      void'(beat_q.pop_front());
    end
    if (beat_q.size() != 0) begin
      r_valid = 1'b1;
      r_beat  = beat_q[0];
    end else begin
      r_valid = 1'b0;
    end
  end

  // Each lane grants after a fresh random delay
  initial begin : lane_grant
    void'($urandom(88));
    forever begin
      @(posedge clk);
      #2;
      for (int l = 0; l < NrLanes; l++) begin
        if (granted[l]) begin
          wait_cnt[l] = $urandom % (max_delay + 1);
        end
        if (!rst_n || grants_held || !ldu_result_req[l]) begin
          ldu_result_gnt[l] = 1'b0;
        end else if (wait_cnt[l] != 0) begin
          ldu_result_gnt[l] = 1'b0;
          wait_cnt[l]--;
        end else begin
          ldu_result_gnt[l] = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers and checks
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_lane_result(input lane_result_t got, input lane_result_t exp,
                                   input int lane);
    logic [LaneBytes*8-1:0] mask;
    mask = '0;
    // Disabled bytes carry no data
    for (int j = 0; j < LaneBytes; j++) begin
      if (exp.be[j]) begin
        mask[8*j +: 8] = 8'hFF;
      end
    end
    checks++;
    if ((got.id !== exp.id) || (got.addr !== exp.addr) || (got.be !== exp.be) ||
        ((got.wdata & mask) !== (exp.wdata & mask))) begin
      errors++;
      $display("FAIL %0t: lane %0d got id %0d addr %0h be %02h data %016h", $time, lane,
               got.id, got.addr, got.be, got.wdata);
      $display("FAIL %0t: lane %0d expected id %0d addr %0h be %02h data %016h", $time, lane,
               exp.id, exp.addr, exp.be, exp.wdata & mask);
    end
  endtask

  task automatic check_resp(input pe_resp_t got, input pe_resp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s done vector %b, expected %b", $time, what,
               got.vinsn_done, exp.vinsn_done);
    end
  endtask

  // Expected lane words, done bit and memory beats for one load
  task automatic expect_load(input pe_req_t req, input logic [7:0] base);
    int           n;
    int           k;
    lane_result_t res;
    r_beat_t      beat;
    pe_resp_t     resp;
    n = int'(req.vl) << int'(req.vsew);
    for (int w = 0; w < (n + WordBytes - 1) / WordBytes; w++) begin
      for (int l = 0; l < NrLanes; l++) begin
        res      = '0;
        res.id   = req.id;
        res.addr = vaddr_t'(int'(req.vd) * WordsPerReg + w);
        for (int j = 0; j < LaneBytes; j++) begin
          k = w * WordBytes + l * LaneBytes + j;
          if (k < n) begin
            res.be[j]            = 1'b1;
            res.wdata[8*j +: 8] = base + 8'(k);
          end
        end
        exp_q[l].push_back(res);
      end
    end
    // Byte value is base plus byte index, tail of the last beat too
    for (int b = 0; b < (n + BeatBytes - 1) / BeatBytes; b++) begin
      for (int j = 0; j < BeatBytes; j++) begin
        beat.data[8*j +: 8] = base + 8'(b * BeatBytes + j);
      end
      beat_q.push_back(beat);
    end
    resp = '0;
    resp.vinsn_done[req.id] = 1'b1;
    resp_exp_q.push_back(resp);
  endtask

  task automatic send_req(input pe_req_t req);
    logic took;
    pe_req       = req;
    pe_req_valid = 1'b1;
    do begin
      @(negedge clk);
      took = pe_req_ready;
      next_cycle();
    end while (!took);
    pe_req_valid = 1'b0;
  endtask

  function automatic bit all_collected();
    bit done;
    done = (resp_got_q.size() >= resp_exp_q.size());
    for (int l = 0; l < NrLanes; l++) begin
      if (got_q[l].size() < exp_q[l].size()) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic start_test();
    test_start_errors = errors;
    tests++;
  endtask

  // Waits for every expected result, then compares in order
  task automatic end_test(input string name);
    while (!all_collected()) begin
      next_cycle();
    end
    for (int l = 0; l < NrLanes; l++) begin
      if (got_q[l].size() != exp_q[l].size()) begin
        errors++;
        $display("Lane %0d received %0d results instead of %0d", l, got_q[l].size(),
                 exp_q[l].size());
      end
      for (int i = 0; i < exp_q[l].size(); i++) begin
        check_lane_result(got_q[l][i], exp_q[l][i], l);
      end
      got_q[l].delete();
      exp_q[l].delete();
    end
    if (resp_got_q.size() != resp_exp_q.size()) begin
      errors++;
      $display("Received %0d done pulses instead of %0d", resp_got_q.size(),
               resp_exp_q.size());
    end
    for (int i = 0; i < resp_exp_q.size(); i++) begin
      check_resp(resp_got_q[i], resp_exp_q[i], name);
    end
    resp_got_q.delete();
    resp_exp_q.delete();
    $display("Test %0d %s: %s", tests, name, (errors == test_start_errors) ? "ok" : "errors");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    check_resp(pe_resp, '0, "after reset");
    checks++;
    if (!pe_req_ready || r_ready || (ldu_result_req != '0)) begin
      errors++;
      $display("FAIL %0t: after reset ready %b, r_ready %b, req %b", $time,
               pe_req_ready, r_ready, ldu_result_req);
    end
  endtask

  task automatic test_single_word();
    pe_req_t req;
    start_test();
    req = '{id: 3'd1, vd: 5'd3, vl: 8'd2, vsew: EW64};
    send_req(req);
    expect_load(req, 8'h10);
    end_test("ew64 single word");
  endtask

  task automatic test_short_load();
    pe_req_t req;
    start_test();
    req = '{id: 3'd2, vd: 5'd4, vl: 8'd5, vsew: EW8};
    send_req(req);
    expect_load(req, 8'h40);
    end_test("ew8 short load");
  endtask

  task automatic test_three_words();
    pe_req_t req;
    start_test();
    req = '{id: 3'd3, vd: 5'd5, vl: 8'd10, vsew: EW32};
    send_req(req);
    expect_load(req, 8'h80);
    end_test("ew32 three words");
  endtask

  // Fifth request must wait until a queued load commits
  task automatic test_queue_full();
    pe_req_t req;
    start_test();
    grants_held = 1'b1;
    for (int i = 0; i < InsnQueueDepth; i++) begin
      req = '{id: vid_t'(4 + i), vd: vreg_t'(8 + i), vl: 8'd2, vsew: EW64};
      send_req(req);
      expect_load(req, 8'(8'h20 * i));
    end
    req = '{id: 3'd0, vd: 5'd12, vl: 8'd2, vsew: EW64};
    expect_load(req, 8'hE0);
    pe_req       = req;
    pe_req_valid = 1'b1;
    repeat (8) begin
      @(negedge clk);
      checks++;
      if (pe_req_ready) begin
        errors++;
        $display("FAIL %0t: pe_req_ready_o high with four loads queued", $time);
      end
      next_cycle();
    end
    grants_held = 1'b0;
    send_req(req);
    end_test("queue full");
  endtask

  task automatic test_random_grants();
    pe_req_t req;
    start_test();
    grants_held = 1'b1;
    max_delay   = 5;
    stall_seen  = 1'b0;
    req = '{id: 3'd2, vd: 5'd16, vl: 8'd32, vsew: EW16};
    send_req(req);
    expect_load(req, 8'hA0);
    // Hold grants until the packer pushes back on memory
    while (!stall_seen) begin
      next_cycle();
    end
    grants_held = 1'b0;
    end_test("random grants");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    clk          = 1'b0;
    rst_n        = 1'b0;
    pe_req       = '0;
    pe_req_valid = 1'b0;
    grants_held  = 1'b0;
    max_delay    = 0;
    stall_seen   = 1'b0;
    cycles       = 0;
    checks       = 0;
    errors       = 0;
    tests        = 0;
    for (int l = 0; l < NrLanes; l++) begin
      wait_cnt[l] = 0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    check_reset_state();
    test_single_word();
    test_short_load();
    test_three_words();
    test_queue_full();
    test_random_grants();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/vldu_beat_packer.sv
// Read-beat packer that builds register-file words with lane address, byte enables and last flag
`timescale 1ns/1ps
`default_nettype none

module vldu_beat_packer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Instruction queue side
  input  vldu_pkg::pe_req_t   issue_req_i,
  input  logic                issue_valid_i,
  output logic                issue_done_o,
  // Memory read channel
  input  vldu_pkg::r_beat_t   r_beat_i,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  // Result queue side
  output vldu_pkg::ldu_word_t word_o,
  output logic                word_valid_o,
  input  logic                word_ready_i
);

  import vldu_pkg::*;

  // Instruction in progress, bytes_left_q holds its remaining count
  logic      started_q;
  byte_cnt_t bytes_left_q;
  // Next free byte in the word under assembly
  logic [$clog2(WordBytes)-1:0] byte_pnt_q;
  vaddr_t    word_idx_q;
  // Word under assembly
  vrf_word_u asm_q;
  logic [WordBytes-1:0] asm_be_q;
  // Output register toward the result queue
  ldu_word_t out_q;
  logic      out_valid_q;

  byte_cnt_t insn_bytes;
  byte_cnt_t rem_bytes;
  byte_cnt_t beat_bytes;
  byte_cnt_t new_rem;
  byte_cnt_t new_pnt;
  logic      beat_fire;
  logic      word_done;
  logic      insn_last;
  vrf_word_u asm_d;
  logic [WordBytes-1:0] asm_be_d;
  ldu_word_t word_d;

  //////////////////////////////////////////////////////////////////////
  // Byte accounting
  //////////////////////////////////////////////////////////////////////

  // vl << vsew, taken fresh for the first beat of an instruction
  assign insn_bytes = byte_cnt_t'(issue_req_i.vl) << issue_req_i.vsew;
  assign rem_bytes  = started_q ? bytes_left_q : insn_bytes;
  // Only the last beat may be partly used
  assign beat_bytes = (rem_bytes > byte_cnt_t'(BeatBytes)) ? byte_cnt_t'(BeatBytes) : rem_bytes;
  assign new_rem    = rem_bytes - beat_bytes;
  assign new_pnt    = byte_cnt_t'(byte_pnt_q) + beat_bytes;

  // Take a beat only if a finished word has somewhere to go
  assign r_ready_o = issue_valid_i && (!out_valid_q || word_ready_i);
  assign beat_fire = r_valid_i && r_ready_o;

  assign insn_last    = (new_rem == '0);
  assign word_done    = (new_pnt >= byte_cnt_t'(WordBytes)) || insn_last;
  assign issue_done_o = beat_fire && insn_last;

  //////////////////////////////////////////////////////////////////////
  // Word assembly
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    asm_d    = asm_q;
    asm_be_d = asm_be_q;
    // Beat bytes go in order from the byte pointer
    for (int b = 0; b < BeatBytes; b++) begin
      if ((b < beat_bytes) && (byte_pnt_q + b < WordBytes)) begin
        asm_d.bytes[byte_pnt_q + b] = r_beat_i.data[8*b +: 8];
        asm_be_d[byte_pnt_q + b]    = 1'b1;
      end
    end
    word_d.id   = issue_req_i.id;
    word_d.addr = vaddr_t'(issue_req_i.vd * WordsPerReg) + word_idx_q;
    word_d.be   = asm_be_d;
    word_d.last = insn_last;
    // Disabled bytes leave as zero
    for (int k = 0; k < WordBytes; k++) begin
      word_d.data.bytes[k] = asm_be_d[k] ? asm_d.bytes[k] : 8'h00;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      asm_q <= asm_d;
    end
    if (beat_fire && word_done) begin
      out_q <= word_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      bytes_left_q <= '0;
      byte_pnt_q   <= '0;
      word_idx_q   <= '0;
      asm_be_q     <= '0;
      out_valid_q  <= 1'b0;
    end else begin
      if (word_ready_i) begin
        out_valid_q <= 1'b0;
      end
      if (beat_fire) begin
        started_q    <= !insn_last;
        bytes_left_q <= new_rem;
        byte_pnt_q   <= new_pnt[$clog2(WordBytes)-1:0];
        asm_be_q     <= asm_be_d;
        if (word_done) begin
          // Word leaves, next one starts empty
          out_valid_q <= 1'b1;
          byte_pnt_q  <= '0;
          asm_be_q    <= '0;
          word_idx_q  <= insn_last ? '0 : word_idx_q + 1'b1;
        end
      end
    end
  end

  assign word_o       = out_q;
  assign word_valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- verilog/vldu_insn_queue.sv
// Load instruction queue with accept, issue and commit pointers and the registered done vector
`timescale 1ns/1ps
`default_nettype none

module vldu_insn_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer side
  input  vldu_pkg::pe_req_t  pe_req_i,
  input  logic               pe_req_valid_i,
  output logic               pe_req_ready_o,
  output vldu_pkg::pe_resp_t pe_resp_o,
  // Packer side
  output vldu_pkg::pe_req_t  issue_req_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  // Result queue side
  input  logic               retire_i,
  input  logic               retire_last_i
);

  import vldu_pkg::*;

  // Instruction storage, written at accept_pnt
  pe_req_t [InsnQueueDepth-1:0] insn_q;

  // One pointer per phase
  logic [$clog2(InsnQueueDepth)-1:0] accept_pnt_q;
  logic [$clog2(InsnQueueDepth)-1:0] issue_pnt_q;
  logic [$clog2(InsnQueueDepth)-1:0] commit_pnt_q;

  // Entries still to issue, and entries still to commit
  logic [$clog2(InsnQueueDepth):0] issue_cnt_q;
  logic [$clog2(InsnQueueDepth):0] commit_cnt_q;

  logic     accept;
  logic     commit;
  pe_resp_t pe_resp_d;

  // An entry is freed only once its last word has retired
  assign pe_req_ready_o = (commit_cnt_q != InsnQueueDepth);
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign commit         = retire_i && retire_last_i;

  assign issue_req_o   = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= pe_req_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and counters
  //////////////////////////////////////////////////////////////////////

  // Depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      // Accept and issue may land in the same cycle
      if (accept && !issue_done_i) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end else if (!accept && issue_done_i) begin
        issue_cnt_q <= issue_cnt_q - 1'b1;
      end
      if (accept && !commit) begin
        commit_cnt_q <= commit_cnt_q + 1'b1;
      end else if (!accept && commit) begin
        commit_cnt_q <= commit_cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Done response
  //////////////////////////////////////////////////////////////////////

  // Single-cycle pulse on the committed id
  always_comb begin
    pe_resp_d = '0;
    if (commit) begin
      pe_resp_d.vinsn_done[insn_q[commit_pnt_q].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_resp_o <= '0;
    end else begin
      pe_resp_o <= pe_resp_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vldu_pkg.sv
// Load unit sizes, id and address types, sequencer structs and the register-file word union
`default_nettype none

package vldu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NrLanes          = 2;
  localparam int unsigned LaneBytes        = 8;
  localparam int unsigned BeatBytes        = 8;
  // One register-file word spans every lane
  localparam int unsigned WordBytes        = NrLanes * LaneBytes;
  // Lane words per vector register, sets the vd stride
  localparam int unsigned WordsPerReg      = 8;
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned NrVInsn          = 8;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0]                 vreg_t;
  typedef logic [7:0]                 vl_t;
  // Wide enough for 255 elements of 8 bytes
  typedef logic [10:0]                byte_cnt_t;
  typedef logic [7:0]                 vaddr_t;

  // Element size in bytes is 1 << encoding
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  //////////////////////////////////////////////////////////////////////
  // Sequencer and memory
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vl_t   vl;
    vsew_e vsew;
  } pe_req_t;

  typedef struct packed {
    logic [NrVInsn-1:0] vinsn_done;
  } pe_resp_t;

  typedef struct packed {
    logic [BeatBytes*8-1:0] data;
  } r_beat_t;

  //////////////////////////////////////////////////////////////////////
  // Register-file word and lane results
  //////////////////////////////////////////////////////////////////////

  // Byte view while packing, lane view on write-back
  // Byte k sits in lane k/8 at byte k%8
  typedef union packed {
    logic [WordBytes-1:0][7:0]         bytes;
    logic [NrLanes-1:0][LaneBytes*8-1:0] lanes;
  } vrf_word_u;

  typedef struct packed {
    vid_t                 id;
    vaddr_t               addr;
    vrf_word_u            data;
    logic [WordBytes-1:0] be;
    logic                 last;
  } ldu_word_t;

  typedef struct packed {
    vid_t                   id;
    vaddr_t                 addr;
    logic [LaneBytes*8-1:0] wdata;
    logic [LaneBytes-1:0]   be;
  } lane_result_t;

endpackage

`default_nettype wire

//--- verilog/vldu_result_queue.sv
// Two-entry result queue with per-lane request/grant write-back and the retire pulse
`timescale 1ns/1ps
`default_nettype none

module vldu_result_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Packer side
  input  vldu_pkg::ldu_word_t    word_i,
  input  logic                   word_valid_i,
  output logic                   word_ready_o,
  // Lane write-back
  output vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] ldu_result_o,
  output logic [vldu_pkg::NrLanes-1:0] ldu_result_req_o,
  input  logic [vldu_pkg::NrLanes-1:0] ldu_result_gnt_i,
  // Instruction queue side
  output logic                   retire_o,
  output logic                   retire_last_o
);

  import vldu_pkg::*;

  ldu_word_t [ResultQueueDepth-1:0] entry_q;
  // Lanes that still owe a grant, per entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0] pending_q, pending_d;
  logic [$clog2(ResultQueueDepth)-1:0] wr_pnt_q, rd_pnt_q;
  logic [$clog2(ResultQueueDepth):0]   cnt_q;

  logic               push;
  logic [NrLanes-1:0] head_pending;
  ldu_word_t          head;

  assign word_ready_o = (cnt_q != ResultQueueDepth);
  assign push         = word_valid_i && word_ready_o;

  assign head         = entry_q[rd_pnt_q];
  assign head_pending = pending_q[rd_pnt_q];

  // Head retires when the last lane still pending grants
  assign retire_o      = (|head_pending) && ((head_pending & ~ldu_result_gnt_i) == '0);
  assign retire_last_o = retire_o && head.last;

  //////////////////////////////////////////////////////////////////////
  // Lane outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      ldu_result_o[l].id    = head.id;
      ldu_result_o[l].addr  = head.addr;
      ldu_result_o[l].wdata = head.data.lanes[l];
      ldu_result_o[l].be    = head.be[l*LaneBytes +: LaneBytes];
    end
    ldu_result_req_o = head_pending;
  end

  //////////////////////////////////////////////////////////////////////
  // Pending bits and pointers
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pending_d = pending_q;
    // Every lane is requested, even with zero enables
    if (push) begin
      pending_d[wr_pnt_q] = '1;
    end
    for (int l = 0; l < NrLanes; l++) begin
      if (head_pending[l] && ldu_result_gnt_i[l]) begin
        pending_d[rd_pnt_q][l] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_pnt_q] <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      wr_pnt_q  <= '0;
      rd_pnt_q  <= '0;
      cnt_q     <= '0;
    end else begin
      pending_q <= pending_d;
      if (push) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (retire_o) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      if (push && !retire_o) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push && retire_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/vldu_top.sv
// Vector load unit top level joining instruction queue, beat packer and result queue
`timescale 1ns/1ps
`default_nettype none

module vldu_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer
  input  vldu_pkg::pe_req_t      pe_req_i,
  input  logic                   pe_req_valid_i,
  output logic                   pe_req_ready_o,
  output vldu_pkg::pe_resp_t     pe_resp_o,
  // Memory read beats
  input  vldu_pkg::r_beat_t      r_beat_i,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  // Lanes
  output vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] ldu_result_o,
  output logic [vldu_pkg::NrLanes-1:0] ldu_result_req_o,
  input  logic [vldu_pkg::NrLanes-1:0] ldu_result_gnt_i
);

  import vldu_pkg::*;

  // Issue path
  pe_req_t   issue_req;
  logic      issue_valid;
  logic      issue_done;
  // Packed words
  ldu_word_t word;
  logic      word_valid;
  logic      word_ready;
  // Commit path
  logic      retire;
  logic      retire_last;

  vldu_insn_queue u_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .pe_resp_o      (pe_resp_o),
    .issue_req_o    (issue_req),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .retire_i       (retire),
    .retire_last_i  (retire_last)
  );

  vldu_beat_packer u_beat_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_req_i   (issue_req),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .r_beat_i      (r_beat_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .word_o        (word),
    .word_valid_o  (word_valid),
    .word_ready_i  (word_ready)
  );

  vldu_result_queue u_result_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .word_i           (word),
    .word_valid_i     (word_valid),
    .word_ready_o     (word_ready),
    .ldu_result_o     (ldu_result_o),
    .ldu_result_req_o (ldu_result_req_o),
    .ldu_result_gnt_i (ldu_result_gnt_i),
    .retire_o         (retire),
    .retire_last_o    (retire_last)
  );

endmodule

`default_nettype wire
